/* common/xrv32i_cfg.svh */
/*
 * Core-wide sizes and constants. Register count and index width must agree.
 * The no-op word is ADDI x0,x0,0 and fills flushed fetch slots.
 */
`ifndef XRV32I_CFG_SVH
`define XRV32I_CFG_SVH

`define XRV_XLEN        32              // data and address width
`define XRV_REG_COUNT   32
`define XRV_REG_ADDR_W  5
`define XRV_RESET_PC    32'h0000_0000   // first fetch after reset
`define XRV_NOP_WORD    32'h0000_0013   // addi x0, x0, 0

`endif

/* common/xrv32i_pkg.sv */
/*
 * Types shared by the core stages. Only the kept RV32I opcodes are listed,
 * every other major opcode decodes to a no-op.
 */
`include "xrv32i_cfg.svh"

package xrv32i_pkg;

    typedef logic [`XRV_XLEN-1:0]       word_t;
    typedef logic [`XRV_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        BRANCH = 7'b1100011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B      // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        EX_ALU,
        EX_BEQ,
        EX_BNE,
        EX_JAL,
        EX_STORE,
        EX_NONE
    } ex_kind_e;

    typedef struct packed {
        logic      valid;
        ex_kind_e  kind;
        alu_op_e   alu_op;
        word_t     opnum1;
        word_t     opnum2;
        reg_addr_t rd;
        logic      reg_we;
        word_t     store_data;  // rs2, also the branch compare operand
        word_t     target;      // branch or jump address
    } id_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

/* logic/core_alu.sv */
/*
 * Combinational ALU. SLT is signed, pass-b serves LUI.
 */
`timescale 1ns/1ps

module core_alu (
    input  xrv32i_pkg::alu_op_e op,
    input  xrv32i_pkg::word_t   a,
    input  xrv32i_pkg::word_t   b,
    output xrv32i_pkg::word_t   result
);
    import xrv32i_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

/* logic/core_regs.sv */
/*
 * 32 x 32 register file, cleared on reset. x0 reads zero.
 * Reads see a write of the same cycle, so decode needs no forwarding.
 */
`timescale 1ns/1ps
`include "xrv32i_cfg.svh"

module core_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  xrv32i_pkg::reg_addr_t  rs1_addr,
    input  xrv32i_pkg::reg_addr_t  rs2_addr,
    input  xrv32i_pkg::reg_write_t wb,
    output xrv32i_pkg::word_t      rs1_data,
    output xrv32i_pkg::word_t      rs2_data
);
    import xrv32i_pkg::*;

    word_t regs [`XRV_REG_COUNT];
    logic  wr_en;

    assign wr_en = wb.we && (wb.addr != '0);   // x0 is never written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `XRV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (wr_en && wb.addr == addr) begin
            return wb.data;             // write-through
        end
        return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

endmodule

/* logic/core_fetch.sv */
/*
 * Program counter and fetch/decode register. inst_in must hold the word at
 * inst_addr_out before the next rising edge. No stalls, only redirects.
 */
`timescale 1ns/1ps
`include "xrv32i_cfg.svh"

module core_fetch (
    input  logic                  clk,
    input  logic                  reset,
    input  xrv32i_pkg::redirect_t redirect,
    input  xrv32i_pkg::word_t     inst_in,
    output xrv32i_pkg::word_t     inst_addr_out,
    output xrv32i_pkg::word_t     if_pc,
    output xrv32i_pkg::word_t     if_inst
);
    import xrv32i_pkg::*;

    word_t pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `XRV_RESET_PC;
        end else if (redirect.valid) begin
            pc <= redirect.target;      // taken branch or jal
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    // the fetched word is dropped on a redirect
    always_ff @(posedge clk) begin
        if (reset || redirect.valid) begin
            if_inst <= `XRV_NOP_WORD;
        end else begin
            if_inst <= inst_in;
        end
        if_pc <= pc;                    // payload only
    end

    assign inst_addr_out = pc;

endmodule

/* logic/core_decode.sv */
/*
 * Decode and decode/execute register. Operands are fully resolved here,
 * execute only sees opnum1/opnum2, rs2 and the target. Unknown words are no-ops.
 */
`timescale 1ns/1ps

module core_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  xrv32i_pkg::word_t     if_pc,
    input  xrv32i_pkg::word_t     if_inst,
    input  xrv32i_pkg::redirect_t redirect,
    input  xrv32i_pkg::word_t     rs1_data,
    input  xrv32i_pkg::word_t     rs2_data,
    output xrv32i_pkg::reg_addr_t rs1_addr,
    output xrv32i_pkg::reg_addr_t rs2_addr,
    output xrv32i_pkg::id_ex_t    id_ex
);
    import xrv32i_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_e    alu_f3;
    logic       f3_ok;
    id_ex_t     id_ex_next;

    assign opcode   = opcode_e'(if_inst[6:0]);
    assign funct3   = if_inst[14:12];
    assign funct7   = if_inst[31:25];
    assign rs1_addr = if_inst[19:15];
    assign rs2_addr = if_inst[24:20];

    assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                    if_inst[11:8], 1'b0};
    assign imm_u = {if_inst[31:12], 12'b0};
    assign imm_j = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                    if_inst[30:21], 1'b0};

    // funct3 map shared by op-imm and op
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  alu_f3 = ALU_ADD;
            3'b010:  alu_f3 = ALU_SLT;
            3'b100:  alu_f3 = ALU_XOR;
            3'b110:  alu_f3 = ALU_OR;
            3'b111:  alu_f3 = ALU_AND;
            default: begin
                alu_f3 = ALU_ADD;
                f3_ok  = 1'b0;          // shifts, sltu
            end
        endcase
    end

    always_comb begin
        id_ex_next.valid      = 1'b1;
        id_ex_next.kind       = EX_NONE;
        id_ex_next.alu_op     = ALU_ADD;
        id_ex_next.opnum1     = rs1_data;
        id_ex_next.opnum2     = imm_i;
        id_ex_next.rd         = if_inst[11:7];
        id_ex_next.reg_we     = 1'b0;
        id_ex_next.store_data = rs2_data;
        id_ex_next.target     = if_pc + imm_b;
        case (opcode)
            OP_IMM: begin
                if (f3_ok) begin
                    id_ex_next.kind   = EX_ALU;
                    id_ex_next.alu_op = alu_f3;
                    id_ex_next.reg_we = 1'b1;
                end
            end
            OP: begin
                id_ex_next.opnum2 = rs2_data;
                if (f3_ok && funct7 == 7'b0000000) begin
                    id_ex_next.kind   = EX_ALU;
                    id_ex_next.alu_op = alu_f3;
                    id_ex_next.reg_we = 1'b1;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    id_ex_next.kind   = EX_ALU; // sub
                    id_ex_next.alu_op = ALU_SUB;
                    id_ex_next.reg_we = 1'b1;
                end
            end
            LUI: begin
                id_ex_next.kind   = EX_ALU;
                id_ex_next.alu_op = ALU_PASS_B;
                id_ex_next.opnum2 = imm_u;
                id_ex_next.reg_we = 1'b1;
            end
            JAL: begin
                id_ex_next.kind   = EX_JAL;
                id_ex_next.opnum1 = if_pc;      // link = pc + 4
                id_ex_next.opnum2 = word_t'(4);
                id_ex_next.reg_we = 1'b1;
                id_ex_next.target = if_pc + imm_j;
            end
            BRANCH: begin
                if (funct3 == 3'b000) begin
                    id_ex_next.kind = EX_BEQ;
                end else if (funct3 == 3'b001) begin
                    id_ex_next.kind = EX_BNE;
                end
            end
            STORE: begin
                if (funct3 == 3'b010) begin
                    id_ex_next.kind   = EX_STORE;   // sw only
                    id_ex_next.opnum2 = imm_s;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_next;
        if (reset || redirect.valid) begin
            id_ex.valid <= 1'b0;        // squash the shadow slot
        end
    end

endmodule

/* logic/core_execute.sv */
/*
 * Execute stage, purely combinational on the decode/execute register.
 * A store is a one-cycle strobe with no back-pressure. Nothing fires unless valid.
 */
`timescale 1ns/1ps

module core_execute (
    input  xrv32i_pkg::id_ex_t     id_ex,
    output xrv32i_pkg::reg_write_t wb,
    output xrv32i_pkg::redirect_t  redirect,
    output logic                   req_out,
    output xrv32i_pkg::word_t      addr_out,
    output xrv32i_pkg::word_t      data_out
);
    import xrv32i_pkg::*;

    word_t alu_result;
    logic  operands_eq;
    logic  taken;

    core_alu alu_inst (
        .op     (id_ex.alu_op),
        .a      (id_ex.opnum1),
        .b      (id_ex.opnum2),
        .result (alu_result)
    );

    assign operands_eq = (id_ex.opnum1 == id_ex.store_data);  // rs1 vs rs2

    always_comb begin
        case (id_ex.kind)
            EX_JAL:  taken = 1'b1;
            EX_BEQ:  taken = operands_eq;
            EX_BNE:  taken = !operands_eq;
            default: taken = 1'b0;
        endcase
    end

    assign redirect.valid  = id_ex.valid && taken;
    assign redirect.target = id_ex.target;

    // alu and jal write back, decode only sets reg_we for those
    assign wb.we   = id_ex.valid && id_ex.reg_we;
    assign wb.addr = id_ex.rd;
    assign wb.data = alu_result;

    assign req_out  = id_ex.valid && (id_ex.kind == EX_STORE);
    assign addr_out = alu_result;       // rs1 + imm_s
    assign data_out = id_ex.store_data;

endmodule

/* logic/xrv32i.sv */
/*
 * RV32I subset core, three stages with no stalls. inst_in is a ROM-like port
 * read one cycle after inst_addr_out. Each req_out cycle is one word store.
 */
`timescale 1ns/1ps

module xrv32i (
    input  logic              clk,
    input  logic              reset,
    input  xrv32i_pkg::word_t inst_in,
    output xrv32i_pkg::word_t inst_addr_out,
    output logic              req_out,
    output xrv32i_pkg::word_t addr_out,
    output xrv32i_pkg::word_t data_out
);
    import xrv32i_pkg::*;

    word_t      if_pc;
    word_t      if_inst;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    id_ex_t     id_ex;
    reg_write_t wb;
    redirect_t  redirect;

    core_fetch fetch_inst (
        .clk           (clk),
        .reset         (reset),
        .redirect      (redirect),
        .inst_in       (inst_in),
        .inst_addr_out (inst_addr_out),
        .if_pc         (if_pc),
        .if_inst       (if_inst)
    );

    core_decode decode_inst (
        .clk      (clk),
        .reset    (reset),
        .if_pc    (if_pc),
        .if_inst  (if_inst),
        .redirect (redirect),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .id_ex    (id_ex)
    );

    core_regs regs_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    core_execute ex_inst (
        .id_ex    (id_ex),
        .wb       (wb),
        .redirect (redirect),      // to fetch and decode
        .req_out  (req_out),
        .addr_out (addr_out),
        .data_out (data_out)
    );

endmodule

/* bench/xrv32i_assertions.sv */
/*
 * Port checks bound to the core top level. Needs assertion support enabled.
 * Alignment checks are off while reset is high.
 */
`timescale 1ns/1ps
`include "xrv32i_cfg.svh"

module xrv32i_assertions (
    input logic              clk,
    input logic              reset,
    input xrv32i_pkg::word_t inst_addr_out,
    input logic              req_out,
    input xrv32i_pkg::word_t addr_out
);

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_addr_out[1:0] == 2'b00)
        else $error("inst_addr_out 0x%08h is not word aligned", inst_addr_out);

    store_aligned: assert property (@(posedge clk) disable iff (reset)
        req_out |-> addr_out[1:0] == 2'b00)
        else $error("store address 0x%08h is not word aligned", addr_out);

    // pipeline is empty for two cycles after reset
    no_early_store: assert property (@(posedge clk)
        $fell(reset) |-> !req_out ##1 !req_out)
        else $error("req_out raised within two cycles of reset release");

    reset_pc: assert property (@(posedge clk)
        $fell(reset) |-> inst_addr_out == `XRV_RESET_PC)
        else $error("first fetch after reset is at 0x%08h", inst_addr_out);

endmodule

bind xrv32i xrv32i_assertions asrt0 (
    .clk           (clk),
    .reset         (reset),
    .inst_addr_out (inst_addr_out),
    .req_out       (req_out),
    .addr_out      (addr_out)
);

/* bench/xrv32i_tb.sv */
/*
 * Testbench for the core. Program words and expected stores come from
 * bench/xrv32i_trace.txt, so run from the project root. Stops at the first error.
 */
`timescale 1ns/1ps
`include "xrv32i_cfg.svh"

module xrv32i_tb;
    import xrv32i_pkg::*;

    localparam int ROM_WORDS     = 256;
    localparam int STORE_TIMEOUT = 400;     // cycles allowed for all stores

    logic  clk;
    logic  reset;
    word_t inst_in;
    word_t inst_addr_out;
    logic  req_out;
    word_t addr_out;
    word_t data_out;

    word_t rom [ROM_WORDS];
    int    rom_used;
    word_t exp_addr [$];
    word_t exp_data [$];

    xrv32i dut0 (
        .clk           (clk),
        .reset         (reset),
        .inst_in       (inst_in),
        .inst_addr_out (inst_addr_out),
        .req_out       (req_out),
        .addr_out      (addr_out),
        .data_out      (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h got 0x%08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        check_word("addr_out", addr, exp_addr.pop_front());
        check_word("data_out", data, exp_data.pop_front());
    endtask

    // words past the loaded program read as no-ops
    function automatic word_t rom_word(input word_t addr);
        word_t idx;
        idx = addr >> 2;
        if (idx < word_t'(rom_used)) begin
            return rom[idx[7:0]];
        end
        return `XRV_NOP_WORD;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        inst_in = rom_word(inst_addr_out);  // pc is settled by now
    endtask

    task automatic load_trace();
        int    fd;
        int    fields;
        string line;
        word_t first;
        word_t second;
        fd = $fopen("bench/xrv32i_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/xrv32i_trace.txt");
            stop_on_failure();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 2 && (line[0] == "P" || line[0] == "S")) begin
                fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", first, second);
                if (fields != 2) begin
                    $display("Trace line could not be parsed: %s", line);
                    stop_on_failure();
                end else if (line[0] == "S") begin
                    exp_addr.push_back(first);
                    exp_data.push_back(second);
                end else if (first >= word_t'(ROM_WORDS)) begin
                    $display("Program index %0d is beyond the instruction ROM", first);
                    stop_on_failure();
                end else begin
                    rom[first[7:0]] = second;
                    if (int'(first) >= rom_used) begin
                        rom_used = int'(first) + 1;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        int idle;
        void'($urandom(32'h7de2));
        reset    = 1'b1;
        inst_in  = `XRV_NOP_WORD;
        rom_used = 0;
        load_trace();
        repeat (3) next_cycle();
        reset = 1'b0;
        check_word("inst_addr_out", inst_addr_out, `XRV_RESET_PC);
        check_word("req_out", word_t'(req_out), '0);

        cycles = 0;
        while (exp_addr.size() > 0 && cycles < STORE_TIMEOUT) begin
            next_cycle();
            cycles++;
            if (req_out) begin
                check_store(addr_out, data_out);
            end
        end

        if (exp_addr.size() > 0) begin
            $display("Timed out after %0d cycles with %0d stores still missing",
                     cycles, exp_addr.size());
            stop_on_failure();
        end else begin
            idle = 24 + int'($urandom % 16);    // core spins on its last jal here
            for (int i = 0; i < idle; i++) begin
                next_cycle();
                if (req_out) begin
                    $display("An extra store to 0x%08h appeared after the program ended",
                             addr_out);
                    stop_on_failure();
                end
            end
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* bench/xrv32i_trace.txt */
# P <rom index, hex> <instruction word, hex> <mnemonic>
# S <store address, hex> <store data, hex>, in issue order
P 00 12300093 addi x1, x0, 0x123
P 01 0F00F113 andi x2, x1, 0x0f0
P 02 50516193 ori  x3, x2, 0x505
P 03 FFF1C213 xori x4, x3, -1
P 04 00022293 slti x5, x4, 0
P 05 00520333 add  x6, x4, x5
P 06 406083B3 sub  x7, x1, x6
P 07 0033F433 and  x8, x7, x3
P 08 002464B3 or   x9, x8, x2
P 09 0074C533 xor  x10, x9, x7
P 0A 00A225B3 slt  x11, x4, x10
P 0B ABCDE637 lui  x12, 0xabcde
P 0C 10402023 sw   x4, 0x100(x0)
P 0D 10702223 sw   x7, 0x104(x0)
P 0E 10A02423 sw   x10, 0x108(x0)
P 0F 10B02623 sw   x11, 0x10c(x0)
P 10 10C02823 sw   x12, 0x110(x0)
P 11 00558663 beq  x11, x5, +12 taken
P 12 1E102823 sw   x1, 0x1f0(x0) skipped
P 13 1E102A23 sw   x1, 0x1f4(x0) skipped
P 14 00209663 bne  x1, x2, +12 taken
P 15 1E102823 sw   x1, 0x1f0(x0) skipped
P 16 1E102A23 sw   x1, 0x1f4(x0) skipped
P 17 00208663 beq  x1, x2, +12 not taken
P 18 10302A23 sw   x3, 0x114(x0)
P 19 00C006EF jal  x13, +12
P 1A 1E102823 sw   x1, 0x1f0(x0) skipped
P 1B 1E102A23 sw   x1, 0x1f4(x0) skipped
P 1C 10D02C23 sw   x13, 0x118(x0)
P 1D 00409113 slli x2, x1, 4 unsupported
P 1E 00508013 addi x0, x1, 5
P 1F 10002E23 sw   x0, 0x11c(x0)
P 20 12202023 sw   x2, 0x120(x0)
P 21 0000006F jal  x0, 0
S 00000100 FFFFFADA
S 00000104 00000648
S 00000108 00000268
S 0000010C 00000001
S 00000110 ABCDE000
S 00000114 00000525
S 00000118 00000068
S 0000011C 00000000
S 00000120 00000020

/* xrv32i.f */
+incdir+common
common/xrv32i_pkg.sv
logic/core_alu.sv
logic/core_regs.sv
logic/core_fetch.sv
logic/core_decode.sv
logic/core_execute.sv
logic/xrv32i.sv
bench/xrv32i_assertions.sv
bench/xrv32i_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the xrv32i testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f xrv32i.f --top-module xrv32i_tb -o xrv32i_sim
./obj_dir/xrv32i_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "Simulation passed" sim.log; then
    echo "run passed"
    exit 0
fi
echo "run failed"
exit 1
